/* verilog.f */
rtl/icache_pkg.sv
rtl/mem_bus_pkg.sv
rtl/icache_tag_array.sv
rtl/icache_data_array.sv
rtl/icache_mem_fetch.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
test/mem_model.sv
test/tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_icache \
  -f verilog.f -o sim_icache > build.log 2>&1 &&
  ./obj_dir/sim_icache > sim.log 2>&1
grep -qx "Test OK" sim.log && echo "simulation passed" ||
  { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* test/icache_stim.txt */
// address  expected_word  expected_memory_requests
// word is address xor 13579bdf, requests counted for that one fetch
00001000 13578BDF 1
00001004 13578BDB 0
0000103C 13578BE3 0
00001020 13578BFF 0
00003000 1357ABDF 1
00003008 1357ABD7 0
00001000 13578BDF 1
00003000 1357ABDF 1
00000040 13579B9F 1
0000007C 13579BA3 0
12345678 0163CDA7 1
12345670 0163CDAF 0
9FFFFFFC 8CA86423 1
9FFFFFF8 8CA86427 0
A0000F00 B35794DF 1
A0000F00 B35794DF 1
A0000F04 B35794DB 1
A0000000 B3579BDF 1
FFFFFFFC ECA86423 1
00001004 13578BDB 1
00001004 13578BDB 0
00003000 1357ABDF 1

/* test/tb_icache.sv */
`timescale 1ns/100ps

module tb_icache;

  localparam int NUM_LINES = 128;
  localparam logic [31:0] UNCACHE_BASE = 32'hA000_0000;
  localparam int TIMEOUT_CYCLES = 2000;

  logic clk;
  logic rst;
  // cpu side
  logic fetch_valid;
  logic [31:0] fetch_addr;
  logic fetch_ready;
  logic inst_valid;
  logic [31:0] inst_data;
  // memory side
  logic mem_req_valid;
  logic mem_req_ready;
  logic [31:0] mem_req_addr;
  logic [7:0] mem_req_len;
  logic mem_rvalid;
  logic [31:0] mem_rdata;
  // request log kept by the memory model
  logic [31:0] req_count;
  logic [31:0] last_req_addr;
  logic [7:0] last_req_len;

  icache_top #(
    .NUM_LINES(NUM_LINES),
    .UNCACHE_BASE(UNCACHE_BASE)
  ) uut (
    .clk(clk),
    .rst(rst),
    .fetch_valid_i(fetch_valid),
    .fetch_addr_i(fetch_addr),
    .fetch_ready_o(fetch_ready),
    .inst_valid_o(inst_valid),
    .inst_data_o(inst_data),
    .mem_req_valid_o(mem_req_valid),
    .mem_req_ready_i(mem_req_ready),
    .mem_req_addr_o(mem_req_addr),
    .mem_req_len_o(mem_req_len),
    .mem_rvalid_i(mem_rvalid),
    .mem_rdata_i(mem_rdata)
  );

  mem_model mem (
    .clk(clk),
    .rst(rst),
    .req_valid_i(mem_req_valid),
    .req_ready_o(mem_req_ready),
    .req_addr_i(mem_req_addr),
    .req_len_i(mem_req_len),
    .rvalid_o(mem_rvalid),
    .rdata_o(mem_rdata),
    .req_count_o(req_count),
    .last_addr_o(last_req_addr),
    .last_len_o(last_req_len)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // one fetch, entered and left on a falling edge
  task automatic run_fetch(input logic [31:0] addr, input logic [31:0] exp_data,
                           input logic [31:0] exp_reqs);
    int waited;
    int latency;
    logic [31:0] count_before;
    logic uncached;
    logic [31:0] exp_req_addr;
    logic [7:0] exp_req_len;
    // uncached goes out as is, cached as a whole line
    uncached = (addr >= UNCACHE_BASE);
    exp_req_addr = uncached ? addr : {addr[31:6], 6'b0};
    exp_req_len = uncached ? 8'd0 : 8'd15;
    waited = 0;
    while (!fetch_ready && (waited < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      waited++;
    end
    assert (fetch_ready) else begin
      $display("timeout: cache never became ready for fetch %h", addr);
      $display("Test FAILED");
      $fatal(1);
    end
    count_before = req_count;
    fetch_valid = 1'b1;
    fetch_addr = addr;
    // accepted at the rising edge in between
    @(negedge clk);
    fetch_valid = 1'b0;
    latency = 1;
    while (!inst_valid && (latency < TIMEOUT_CYCLES)) begin
      @(negedge clk);
      latency++;
    end
    assert (inst_valid) else begin
      $display("timeout: no instruction returned for fetch %h", addr);
      $display("Test FAILED");
      $fatal(1);
    end
    assert (inst_data === exp_data) else begin
      $display("Mismatch at %0d ns: fetch %h returned %h, expected %h",
               $time, addr, inst_data, exp_data);
      $display("Test FAILED");
      $fatal(1);
    end
    assert ((req_count - count_before) == exp_reqs) else begin
      $display("Mismatch at %0d ns: fetch %h made %0d memory requests, expected %0d",
               $time, addr, req_count - count_before, exp_reqs);
      $display("Test FAILED");
      $fatal(1);
    end
    if (exp_reqs != 32'd0) begin
      assert ((last_req_addr == exp_req_addr) && (last_req_len == exp_req_len)) else begin
        $display("Mismatch at %0d ns: request %h len %0d, expected %h len %0d",
                 $time, last_req_addr, last_req_len, exp_req_addr, exp_req_len);
        $display("Test FAILED");
        $fatal(1);
      end
    end else begin
      // hit answers in the cycle after acceptance
      assert (latency == 1) else begin
        $display("Mismatch at %0d ns: hit on %h took %0d cycles, expected 1",
                 $time, addr, latency);
        $display("Test FAILED");
        $fatal(1);
      end
    end
    @(negedge clk);
    assert (!inst_valid) else begin
      $display("inst_valid_o stayed high for more than one cycle after fetch %h", addr);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    int fd;
    int fields;
    int num_fetches;
    string line;
    logic [31:0] addr;
    logic [31:0] exp_data;
    logic [31:0] exp_reqs;
    fetch_valid = 1'b0;
    fetch_addr = '0;
    rst = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    assert (fetch_ready && !inst_valid && !mem_req_valid) else begin
      $display("cache not idle after reset");
      $display("Test FAILED");
      $fatal(1);
    end
    fd = $fopen("test/icache_stim.txt", "r");
    assert (fd != 0) else begin
      $display("could not open test/icache_stim.txt");
      $display("Test FAILED");
      $fatal(1);
    end
    num_fetches = 0;
    // comment and blank lines scan no fields
    while ($fgets(line, fd) != 0) begin
      fields = $sscanf(line, "%h %h %d", addr, exp_data, exp_reqs);
      if (fields == 3) begin
        run_fetch(addr, exp_data, exp_reqs);
        num_fetches++;
      end
    end
    $fclose(fd);
    assert (num_fetches > 0) else begin
      $display("stimulus file held no fetch lines");
      $display("Test FAILED");
      $fatal(1);
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* test/mem_model.sv */
`timescale 1ns/100ps

module mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  logic [31:0] req_addr_i,
  input  logic [7:0]  req_len_i,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic [31:0] req_count_o,
  output logic [31:0] last_addr_o,
  output logic [7:0]  last_len_o
);

  integer seed;
  logic [31:0] rnd;
  // open burst, beats still owed and next beat address
  logic [8:0] beats_left;
  logic [31:0] beat_addr;
  logic ready_now;

  // memory content is a pure function of the address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ 32'h1357_9BDF;
  endfunction

  initial begin
    seed = 32'h2805;
    req_ready_o = 1'b0;
    rvalid_o = 1'b0;
    rdata_o = '0;
    req_count_o = '0;
    last_addr_o = '0;
    last_len_o = '0;
    beats_left = '0;
    beat_addr = '0;
  end

  // all outputs change on the falling edge only
  always @(negedge clk) begin
    if (rst) begin
      req_ready_o <= 1'b0;
      rvalid_o <= 1'b0;
      req_count_o <= '0;
      beats_left = '0;
    end else begin
      rnd = $random(seed);
      // beats of the accepted request, gap one time in four
      if ((beats_left != 9'd0) && (rnd[3:2] != 2'b00)) begin
        rvalid_o <= 1'b1;
        rdata_o <= mem_word(beat_addr);
        beat_addr = beat_addr + 32'd4;
        beats_left = beats_left - 9'd1;
      end else begin
        rvalid_o <= 1'b0;
      end
      // ready stalls, no new request while a burst is open
      ready_now = (beats_left == 9'd0) && (rnd[1:0] != 2'b00);
      req_ready_o <= ready_now;
      // request valid is registered in the cache
      // so what is seen now is what the next rising edge takes
      if (req_valid_i && ready_now) begin
        req_count_o <= req_count_o + 32'd1;
        last_addr_o <= req_addr_i;
        last_len_o <= req_len_i;
        beats_left = {1'b0, req_len_i} + 9'd1;
        beat_addr = req_addr_i;
      end
    end
  end

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/100ps

module icache_top
  import icache_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int NUM_LINES = 128,
  parameter logic [XLEN-1:0] UNCACHE_BASE = 32'hA000_0000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 fetch_valid_i,
  input  logic [XLEN-1:0]      fetch_addr_i,
  output logic                 fetch_ready_o,
  output logic                 inst_valid_o,
  output logic [XLEN-1:0]      inst_data_o,
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output logic [XLEN-1:0]      mem_req_addr_o,
  output logic [MEM_LEN_W-1:0] mem_req_len_o,
  input  logic                 mem_rvalid_i,
  input  logic [XLEN-1:0]      mem_rdata_i
);

  localparam int INDEX_W = $clog2(NUM_LINES);
  localparam int TAG_W = XLEN - INDEX_W - OFFSET_W;

  // controller to tag array
  logic [INDEX_W-1:0] lookup_index;
  logic [TAG_W-1:0] lookup_tag;
  logic hit;
  logic tag_wr_en;
  // controller to data array
  logic [INDEX_W-1:0] rd_index;
  logic [WORD_SEL_W-1:0] rd_word;
  logic [XLEN-1:0] rd_data;
  logic [INDEX_W-1:0] refill_index;
  // controller and fetch unit
  logic fill_start;
  mem_op_e fill_op;
  logic [XLEN-1:0] fill_addr;
  logic fill_done;
  // beats, shared by controller and data array write port
  logic beat_valid;
  logic [BEAT_CNT_W-1:0] beat_idx;
  logic [XLEN-1:0] beat_data;
  // only line refill beats land in the array
  logic beat_wr_en;

  // uncached beats bypass the line storage
  assign beat_wr_en = beat_valid && (fill_op == MEM_OP_LINE);

  icache_ctrl #(
    .NUM_LINES(NUM_LINES),
    .UNCACHE_BASE(UNCACHE_BASE)
  ) u_ctrl (
    .clk(clk),
    .rst(rst),
    .fetch_valid_i(fetch_valid_i),
    .fetch_addr_i(fetch_addr_i),
    .hit_i(hit),
    .rd_data_i(rd_data),
    .fill_done_i(fill_done),
    .beat_valid_i(beat_valid),
    .beat_data_i(beat_data),
    .fetch_ready_o(fetch_ready_o),
    .inst_valid_o(inst_valid_o),
    .inst_data_o(inst_data_o),
    .lookup_index_o(lookup_index),
    .lookup_tag_o(lookup_tag),
    .rd_index_o(rd_index),
    .rd_word_o(rd_word),
    .tag_wr_en_o(tag_wr_en),
    .fill_start_o(fill_start),
    .fill_op_o(fill_op),
    .fill_addr_o(fill_addr),
    .refill_index_o(refill_index)
  );

  icache_tag_array #(
    .NUM_LINES(NUM_LINES)
  ) u_tag_array (
    .clk(clk),
    .rst(rst),
    .lookup_index_i(lookup_index),
    .lookup_tag_i(lookup_tag),
    .wr_en_i(tag_wr_en),
    .hit_o(hit)
  );

  icache_data_array #(
    .NUM_LINES(NUM_LINES)
  ) u_data_array (
    .clk(clk),
    .rd_index_i(rd_index),
    .rd_word_i(rd_word),
    .wr_en_i(beat_wr_en),
    .wr_index_i(refill_index),
    .wr_word_i(beat_idx),
    .wr_data_i(beat_data),
    .rd_data_o(rd_data)
  );

  icache_mem_fetch u_mem_fetch (
    .clk(clk),
    .rst(rst),
    .fill_start_i(fill_start),
    .fill_op_i(fill_op),
    .fill_addr_i(fill_addr),
    .mem_req_ready_i(mem_req_ready_i),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i(mem_rdata_i),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_req_addr_o(mem_req_addr_o),
    .mem_req_len_o(mem_req_len_o),
    .beat_valid_o(beat_valid),
    .beat_idx_o(beat_idx),
    .beat_data_o(beat_data),
    .fill_done_o(fill_done)
  );

endmodule

/* rtl/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl
  import icache_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int NUM_LINES = 128,
  parameter logic [XLEN-1:0] UNCACHE_BASE = 32'hA000_0000
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               fetch_valid_i,
  input  logic [XLEN-1:0]                    fetch_addr_i,
  input  logic                               hit_i,
  input  logic [XLEN-1:0]                    rd_data_i,
  input  logic                               fill_done_i,
  input  logic                               beat_valid_i,
  input  logic [XLEN-1:0]                    beat_data_i,
  output logic                               fetch_ready_o,
  output logic                               inst_valid_o,
  output logic [XLEN-1:0]                    inst_data_o,
  output logic [$clog2(NUM_LINES)-1:0]       lookup_index_o,
  output logic [XLEN-$clog2(NUM_LINES)-OFFSET_W-1:0] lookup_tag_o,
  output logic [$clog2(NUM_LINES)-1:0]       rd_index_o,
  output logic [WORD_SEL_W-1:0]              rd_word_o,
  output logic                               tag_wr_en_o,
  output logic                               fill_start_o,
  output mem_op_e                            fill_op_o,
  output logic [XLEN-1:0]                    fill_addr_o,
  output logic [$clog2(NUM_LINES)-1:0]       refill_index_o
);

  localparam int INDEX_W = $clog2(NUM_LINES);
  localparam int TAG_W = XLEN - INDEX_W - OFFSET_W;

  icache_state_e state_q;
  icache_state_e state_d;
  // captured request
  logic [XLEN-1:0] addr_q;
  logic uncached_q;
  // uncached beat, returned one cycle later
  logic uc_valid_q;
  logic [XLEN-1:0] uc_data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      uc_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      uc_valid_q <= (state_q == UNCACHED) && beat_valid_i;
    end
  end

  // request capture at acceptance, uncached decode done once here
  always_ff @(posedge clk) begin
    if (fetch_valid_i && fetch_ready_o) begin
      addr_q <= fetch_addr_i;
      uncached_q <= (fetch_addr_i >= UNCACHE_BASE);
    end
    if ((state_q == UNCACHED) && beat_valid_i) begin
      uc_data_q <= beat_data_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (fetch_valid_i) state_d = LOOKUP;
      LOOKUP: begin
        if (uncached_q) state_d = UNCACHED;
        else if (hit_i) state_d = IDLE;
        else state_d = REFILL;
      end
      // tag written on the last beat, then look again
      REFILL: if (fill_done_i) state_d = REPLAY;
      UNCACHED: if (beat_valid_i) state_d = IDLE;
      // data read reissued here, lands in LOOKUP
      REPLAY: state_d = LOOKUP;
      default: state_d = IDLE;
    endcase
  end

  assign fetch_ready_o = (state_q == IDLE);

  // read issued at acceptance from the raw address, otherwise from the capture
  assign rd_index_o = (state_q == IDLE) ? fetch_addr_i[OFFSET_W +: INDEX_W]
                                        : addr_q[OFFSET_W +: INDEX_W];
  assign rd_word_o = (state_q == IDLE) ? fetch_addr_i[2 +: WORD_SEL_W]
                                       : addr_q[2 +: WORD_SEL_W];

  assign lookup_index_o = addr_q[OFFSET_W +: INDEX_W];
  assign lookup_tag_o = addr_q[XLEN-1 -: TAG_W];
  assign refill_index_o = addr_q[OFFSET_W +: INDEX_W];
  assign tag_wr_en_o = (state_q == REFILL) && fill_done_i;

  // miss or uncached starts one memory read
  assign fill_start_o = (state_q == LOOKUP) && (uncached_q || !hit_i);
  assign fill_op_o = uncached_q ? MEM_OP_SINGLE : MEM_OP_LINE;
  assign fill_addr_o = uncached_q ? addr_q : {addr_q[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // hit never counts for an uncached address
  assign inst_valid_o = ((state_q == LOOKUP) && hit_i && !uncached_q) || uc_valid_q;
  assign inst_data_o = uc_valid_q ? uc_data_q : rd_data_i;

  // no response may leave while a line is still streaming in
  a_no_resp_in_refill: assert property (
    @(posedge clk) disable iff (rst) (state_q == REFILL) |-> !inst_valid_o);

endmodule

/* rtl/icache_mem_fetch.sv */
`timescale 1ns/100ps

module icache_mem_fetch
  import mem_bus_pkg::*;
  import icache_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  fill_start_i,
  input  mem_op_e               fill_op_i,
  input  logic [XLEN-1:0]       fill_addr_i,
  input  logic                  mem_req_ready_i,
  input  logic                  mem_rvalid_i,
  input  logic [XLEN-1:0]       mem_rdata_i,
  output logic                  mem_req_valid_o,
  output logic [XLEN-1:0]       mem_req_addr_o,
  output logic [MEM_LEN_W-1:0]  mem_req_len_o,
  output logic                  beat_valid_o,
  output logic [BEAT_CNT_W-1:0] beat_idx_o,
  output logic [XLEN-1:0]       beat_data_o,
  output logic                  fill_done_o
);

  // beats in one line, minus one
  localparam int LINE_LEN = LINE_BYTES / (XLEN / 8) - 1;

  // control state
  logic req_valid_q;
  logic busy_q;
  logic [BEAT_CNT_W-1:0] beat_cnt_q;
  // request payload, held until the handshake
  logic [XLEN-1:0] addr_q;
  logic [MEM_LEN_W-1:0] len_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_q <= 1'b0;
      busy_q <= 1'b0;
      beat_cnt_q <= '0;
    end else if (fill_start_i) begin
      req_valid_q <= 1'b1;
      busy_q <= 1'b1;
      beat_cnt_q <= '0;
    end else begin
      // request leaves on the handshake
      if (req_valid_q && mem_req_ready_i) begin
        req_valid_q <= 1'b0;
      end
      if (beat_valid_o) begin
        beat_cnt_q <= beat_cnt_q + 1'b1;
      end
      if (fill_done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start_i) begin
      addr_q <= fill_addr_i;
      len_q <= (fill_op_i == MEM_OP_LINE) ? MEM_LEN_W'(LINE_LEN) : '0;
    end
  end

  assign mem_req_valid_o = req_valid_q;
  assign mem_req_addr_o = addr_q;
  assign mem_req_len_o = len_q;

  // every beat taken while a read is open
  assign beat_valid_o = busy_q && mem_rvalid_i;
  assign beat_idx_o = beat_cnt_q;
  assign beat_data_o = mem_rdata_i;
  // last beat when the count reaches the length field
  assign fill_done_o = beat_valid_o && (beat_cnt_q == len_q[BEAT_CNT_W-1:0]);

  // request held steady under back-pressure
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    (mem_req_valid_o && !mem_req_ready_i) |=>
      (mem_req_valid_o && $stable(mem_req_addr_o) && $stable(mem_req_len_o)));

endmodule

/* rtl/icache_data_array.sv */
`timescale 1ns/100ps

module icache_data_array
  import icache_pkg::*;
#(
  parameter int NUM_LINES = 128
) (
  input  logic                         clk,
  input  logic [$clog2(NUM_LINES)-1:0] rd_index_i,
  input  logic [WORD_SEL_W-1:0]        rd_word_i,
  input  logic                         wr_en_i,
  input  logic [$clog2(NUM_LINES)-1:0] wr_index_i,
  input  logic [WORD_SEL_W-1:0]        wr_word_i,
  input  logic [XLEN-1:0]              wr_data_i,
  output logic [XLEN-1:0]              rd_data_o
);

  // line storage, one word per beat
  logic [XLEN-1:0] mem [NUM_LINES][WORDS_PER_LINE];

  // refill beat write
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_index_i][wr_word_i] <= wr_data_i;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data_o <= mem[rd_index_i][rd_word_i];
  end

  // index from the controller must stay inside the array
  // matters for line counts that are not a power of two
  a_wr_index_range: assert property (
    @(posedge clk) wr_en_i |-> (int'(wr_index_i) < NUM_LINES));

endmodule

/* rtl/icache_tag_array.sv */
`timescale 1ns/100ps

module icache_tag_array
  import icache_pkg::*;
#(
  parameter int NUM_LINES = 128
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [$clog2(NUM_LINES)-1:0]               lookup_index_i,
  input  logic [XLEN-$clog2(NUM_LINES)-OFFSET_W-1:0] lookup_tag_i,
  input  logic                                       wr_en_i,
  output logic                                       hit_o
);

  localparam int INDEX_W = $clog2(NUM_LINES);
  localparam int TAG_W = XLEN - INDEX_W - OFFSET_W;

  // one valid bit per line, cleared at reset
  logic [NUM_LINES-1:0] valid_q;
  // tag store
  logic [TAG_W-1:0] tag_mem [NUM_LINES];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[lookup_index_i] <= 1'b1;
    end
  end

  // write lands on the lookup index
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_mem[lookup_index_i] <= lookup_tag_i;
    end
  end

  // combinational compare against the stored tag
  assign hit_o = valid_q[lookup_index_i] && (tag_mem[lookup_index_i] == lookup_tag_i);

endmodule

/* rtl/mem_bus_pkg.sv */
package mem_bus_pkg;

  // read opcode from controller to fetch unit
  // line burst or single beat
  typedef enum logic [0:0] {
    MEM_OP_LINE   = 1'b0,
    MEM_OP_SINGLE = 1'b1
  } mem_op_e;

  // burst length field, beats minus one
  localparam int MEM_LEN_W = 8;

  // beat counter, covers one line of words
  localparam int BEAT_CNT_W = 4;

endpackage

/* rtl/icache_pkg.sv */
package icache_pkg;

  // address and instruction word width
  localparam int XLEN = 32;

  // line geometry, 64 bytes per line
  localparam int LINE_BYTES = 64;
  localparam int OFFSET_W = 6;
  localparam int WORDS_PER_LINE = 16;
  localparam int WORD_SEL_W = 4;

  // controller states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    LOOKUP   = 3'd1,
    REFILL   = 3'd2,
    UNCACHED = 3'd3,
    REPLAY   = 3'd4
  } icache_state_e;

endpackage
